/* design/xlat_cfg.svh */
/*
 * widths and ratios of the master translator
 *   upstream word address, data, byte enable and word burst count
 *   downstream byte address and byte count
 *   bytes-per-word shift between the two sides
 */
`ifndef XLAT_CFG_SVH
`define XLAT_CFG_SVH

// ----------------------------------------------------------------------
// upstream, word addressed
// ----------------------------------------------------------------------
`define XLAT_AV_ADDR_W   30
`define XLAT_DATA_W      32
`define XLAT_BE_W        4
// burst of up to 8 words
`define XLAT_AV_BURST_W  4

// log2 of bytes per word
`define XLAT_SYM_SHIFT   2

// ----------------------------------------------------------------------
// downstream, byte addressed
// ----------------------------------------------------------------------
`define XLAT_UAV_ADDR_W  32
`define XLAT_UAV_BURST_W 6

`endif

/* design/av_side_pkg.sv */
/*
 * types of the upstream, word-addressed side
 *   word address and word burst count fields
 *   one command beat as issued by the master
 */
`include "xlat_cfg.svh"

package av_side_pkg;

   typedef logic [`XLAT_AV_ADDR_W-1:0]  av_addr_t;
   typedef logic [`XLAT_AV_BURST_W-1:0] av_burst_t;

   // one upstream beat, held by the master while av_waitrequest is high
   typedef struct packed {
      logic                   write;
      logic                   read;
      av_addr_t               address;
      logic [`XLAT_BE_W-1:0]   byteenable;
      // burst length in words
      av_burst_t              burstcount;
      logic [`XLAT_DATA_W-1:0] writedata;
   } av_cmd_t;

endpackage

/* design/uav_side_pkg.sv */
/*
 * types of the downstream, byte-addressed side
 *   byte address and byte count fields
 *   one command beat in byte units
 *   read data return shared by both sides
 */
`include "xlat_cfg.svh"

package uav_side_pkg;

   typedef logic [`XLAT_UAV_ADDR_W-1:0]  uav_addr_t;
   typedef logic [`XLAT_UAV_BURST_W-1:0] uav_burst_t;

   // one downstream beat
   typedef struct packed {
      logic                   write;
      logic                   read;
      uav_addr_t              address;
      // remaining length in bytes
      uav_burst_t             burstcount;
      logic [`XLAT_BE_W-1:0]   byteenable;
      logic [`XLAT_DATA_W-1:0] writedata;
   } uav_cmd_t;

   // read return, passed to the master unchanged
   typedef struct packed {
      logic [`XLAT_DATA_W-1:0] readdata;
      logic                   readdatavalid;
   } uav_rdata_t;

endpackage

/* design/pipe_stage.sv */
/*
 * one-entry registered stage with a valid/ready handshake
 *   payload type set by parameter
 *   accepts a new item every cycle while the output keeps moving
 */

module pipe_stage #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     reset,

   input  payload_t in_data,
   input  logic     in_valid,
   output logic     in_ready,

   output payload_t out_data,
   output logic     out_valid,
   input  logic     out_ready
);

   logic     full;
   payload_t data_q;

   // room when empty or when the held item leaves this cycle
   assign in_ready = ~full | out_ready;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         full <= 1'b0;
      end else if (in_ready) begin
         full <= in_valid;
      end
   end

   // holding register loaded on every ready cycle
   always_ff @(posedge clk) begin
      if (in_ready) begin
         data_q <= in_data;
      end
   end

   assign out_data  = data_q;
   assign out_valid = full;

endmodule

/* design/cmd_widen.sv */
/*
 * word to byte conversion of an upstream command
 *   address and burst count shifted by the bytes-per-word shift
 *   result registered through one pipe stage
 */
`include "xlat_cfg.svh"

module cmd_widen
   import av_side_pkg::*;
   import uav_side_pkg::*;
(
   input  logic     clk,
   input  logic     reset,

   input  av_cmd_t  cmd_in,
   input  logic     in_valid,
   output logic     in_ready,

   output uav_cmd_t cmd_out,
   output logic     out_valid,
   input  logic     out_ready
);

   uav_cmd_t widened;

   // ----------------------------------------------------------------------
   // word units to byte units
   // ----------------------------------------------------------------------
   always_comb begin
      widened.write      = cmd_in.write;
      widened.read       = cmd_in.read;
      widened.address    = uav_addr_t'(cmd_in.address) << `XLAT_SYM_SHIFT;
      // burst of N words becomes N * bytes per word
      widened.burstcount = uav_burst_t'(cmd_in.burstcount) << `XLAT_SYM_SHIFT;
      widened.byteenable = cmd_in.byteenable;
      widened.writedata  = cmd_in.writedata;
   end

   // ----------------------------------------------------------------------
   // second register stage
   // ----------------------------------------------------------------------
   pipe_stage #(
      .payload_t (uav_cmd_t)
   ) widen_stage_i (
      .clk       (clk),
      .reset     (reset),
      .in_data   (widened),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_data  (cmd_out),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

endmodule

/* design/beat_tracker.sv */
/*
 * per-beat address and count generation for write bursts
 *   first beat of a burst goes out with the command's own fields
 *   later beats take a running address and remaining count
 *   reads leave as one beat carrying the whole count
 */
`include "xlat_cfg.svh"

module beat_tracker
   import uav_side_pkg::*;
(
   input  logic     clk,
   input  logic     reset,

   input  uav_cmd_t cmd_in,
   input  logic     in_valid,
   output logic     in_ready,

   output uav_cmd_t uav_cmd,
   input  logic     uav_waitrequest
);

   // one word in byte units, for the address and for the count
   localparam uav_addr_t  ADDR_STEP  = uav_addr_t'(1 << `XLAT_SYM_SHIFT);
   localparam uav_burst_t COUNT_STEP = uav_burst_t'(1 << `XLAT_SYM_SHIFT);

   // burst state
   logic       in_burst;
   uav_addr_t  addr_q;
   uav_burst_t count_q;

   // current beat
   logic       beat_write;
   logic       beat_read;
   logic       use_regs;
   logic       write_taken;
   logic       last_beat;
   uav_addr_t  cur_addr;
   uav_burst_t cur_count;

   // ----------------------------------------------------------------------
   // beat selection
   // ----------------------------------------------------------------------
   assign beat_write = in_valid & cmd_in.write;
   assign beat_read  = in_valid & cmd_in.read;

   // after the first write beat the incoming fields are ignored
   assign use_regs  = in_burst & cmd_in.write;
   assign cur_addr  = use_regs ? addr_q : cmd_in.address;
   assign cur_count = use_regs ? count_q : cmd_in.burstcount;

   // a beat holds while the slave stalls
   assign in_ready    = ~uav_waitrequest;
   assign write_taken = beat_write & ~uav_waitrequest;
   assign last_beat   = (cur_count == COUNT_STEP);

   // ----------------------------------------------------------------------
   // downstream command
   // ----------------------------------------------------------------------
   always_comb begin
      uav_cmd            = cmd_in;
      uav_cmd.write      = beat_write;
      uav_cmd.read       = beat_read;
      uav_cmd.address    = cur_addr;
      uav_cmd.burstcount = cur_count;
   end

   // ----------------------------------------------------------------------
   // burst tracking
   // ----------------------------------------------------------------------

   // set by the first accepted write beat of a multi-word burst,
   // cleared when the beat with one word left is accepted
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         in_burst <= 1'b0;
      end else if (write_taken) begin
         in_burst <= ~last_beat;
      end
   end

   // next beat is one word higher with one word less to go
   always_ff @(posedge clk) begin
      if (write_taken) begin
         addr_q  <= cur_addr + ADDR_STEP;
         count_q <= cur_count - COUNT_STEP;
      end
   end

endmodule

/* design/xlat_top.sv */
/*
 * master translator top level
 *   upstream register stage, word to byte conversion stage
 *   write burst beat tracking toward the downstream bus
 *   read data returned straight to the master
 */

module xlat_top
   import av_side_pkg::*;
   import uav_side_pkg::*;
(
   input  logic       clk,
   input  logic       reset,

   // upstream master
   input  av_cmd_t    av_cmd,
   output logic       av_waitrequest,
   output uav_rdata_t av_rdata,

   // downstream bus
   output uav_cmd_t   uav_cmd,
   input  logic       uav_waitrequest,
   input  uav_rdata_t uav_rdata
);

   logic     av_valid;
   logic     av_ready;

   av_cmd_t  cmd_q;
   logic     cmd_q_valid;
   logic     cmd_q_ready;

   uav_cmd_t wide_cmd;
   logic     wide_valid;
   logic     wide_ready;

   // ----------------------------------------------------------------------
   // upstream handshake
   // ----------------------------------------------------------------------
   assign av_valid       = av_cmd.read | av_cmd.write;
   assign av_waitrequest = ~av_ready;

   // first register stage, still in word units
   pipe_stage #(
      .payload_t (av_cmd_t)
   ) av_stage_i (
      .clk       (clk),
      .reset     (reset),
      .in_data   (av_cmd),
      .in_valid  (av_valid),
      .in_ready  (av_ready),
      .out_data  (cmd_q),
      .out_valid (cmd_q_valid),
      .out_ready (cmd_q_ready)
   );

   cmd_widen cmd_widen_i (
      .clk       (clk),
      .reset     (reset),
      .cmd_in    (cmd_q),
      .in_valid  (cmd_q_valid),
      .in_ready  (cmd_q_ready),
      .cmd_out   (wide_cmd),
      .out_valid (wide_valid),
      .out_ready (wide_ready)
   );

   beat_tracker beat_tracker_i (
      .clk             (clk),
      .reset           (reset),
      .cmd_in          (wide_cmd),
      .in_valid        (wide_valid),
      .in_ready        (wide_ready),
      .uav_cmd         (uav_cmd),
      .uav_waitrequest (uav_waitrequest)
   );

   // read return needs no translation
   assign av_rdata = uav_rdata;

endmodule

/* dv/xlat_model.svh */
/*
 * reference model of the master translator
 *   xorshift random source
 *   expected downstream beats and expected read words, in order
 *   checks of accepted beats, returned words and the idle bus after reset
 */

// random source
logic [31:0] rng_state;

// expected traffic in issue order
uav_cmd_t                exp_beats[$];
logic [`XLAT_DATA_W-1:0] exp_words[$];

// write burst as seen upstream
av_addr_t  burst_base;
av_burst_t burst_len;
av_burst_t burst_idx;

logic first_accepted;
int   beats_seen;
int   words_seen;

function automatic logic [31:0] next_rand();
   logic [31:0] x;
   x = rng_state;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   rng_state = x;
   return x;
endfunction

task automatic clear_model();
   exp_beats.delete();
   exp_words.delete();
   burst_base     = '0;
   burst_len      = '0;
   burst_idx      = '0;
   first_accepted = 1'b0;
   beats_seen     = 0;
   words_seen     = 0;
endtask

// ----------------------------------------------------------------------
// expected results of one accepted upstream beat
// ----------------------------------------------------------------------
task automatic record_upstream(input av_cmd_t c);
   uav_cmd_t  e;
   av_burst_t k;
   e              = '0;
   e.byteenable   = c.byteenable;
   e.writedata    = c.writedata;
   first_accepted = 1'b1;
   if (c.read) begin
      // whole read leaves as one beat
      e.read       = 1'b1;
      e.address    = uav_addr_t'(c.address) * 32'd4;
      e.burstcount = uav_burst_t'(c.burstcount) * 6'd4;
      for (k = '0; k < c.burstcount; k = k + 4'd1) begin
         exp_words.push_back(((uav_addr_t'(c.address) + uav_addr_t'(k)) * 32'd4) ^ RD_KEY);
      end
   end else begin
      // address and count of the burst come from its first beat
      if (burst_idx == 4'd0) begin
         burst_base = c.address;
         burst_len  = c.burstcount;
      end
      e.write      = 1'b1;
      e.address    = (uav_addr_t'(burst_base) + uav_addr_t'(burst_idx)) * 32'd4;
      e.burstcount = uav_burst_t'(burst_len - burst_idx) * 6'd4;
      burst_idx    = burst_idx + 4'd1;
      if (burst_idx == burst_len) begin
         burst_idx = '0;
      end
   end
   exp_beats.push_back(e);
endtask

// ----------------------------------------------------------------------
// checks
// ----------------------------------------------------------------------
task automatic check_beat(input uav_cmd_t got);
   uav_cmd_t exp;
   assert (exp_beats.size() != 0)
      else abort_run("a downstream beat was accepted while no beat was expected");
   exp = exp_beats.pop_front();
   assert (got == exp)
      else abort_run($sformatf("FAILED downstream beat %0d: expected %h, actual %h",
                               beats_seen, exp, got));
   beats_seen++;
endtask

task automatic check_read_word(input logic [`XLAT_DATA_W-1:0] got);
   logic [`XLAT_DATA_W-1:0] exp;
   assert (exp_words.size() != 0)
      else abort_run("read data arrived upstream while no read word was outstanding");
   exp = exp_words.pop_front();
   assert (got == exp)
      else abort_run($sformatf("FAILED read word %0d: expected %h, actual %h",
                               words_seen, exp, got));
   words_seen++;
endtask

// downstream stays quiet until the first command gets in
task automatic check_bus_idle();
   if (!first_accepted) begin
      assert (!(uav_cmd.write || uav_cmd.read))
         else abort_run("downstream read or write was raised before any command was accepted");
   end
endtask

/* dv/tb_xlat_top.sv */
/*
 * testbench of the master translator
 *   clock, reset and DUT
 *   random upstream traffic and a downstream memory responder
 *   cycle limit against a hung run
 */
`include "xlat_cfg.svh"

module tb_xlat_top
   import av_side_pkg::*;
   import uav_side_pkg::*;
();

   localparam int CLK_PERIOD      = 40;
   localparam int RESET_CYCLES    = 8;
   localparam int NUM_CMDS        = 300;
   localparam int CYCLES_PER_BEAT = 40;
   localparam int TIMEOUT_MARGIN  = 200;
   // read words hold their byte address xor this
   localparam logic [`XLAT_DATA_W-1:0] RD_KEY = 32'h5a3c_96e1;

   logic       clk;
   logic       reset;
   av_cmd_t    av_cmd;
   logic       av_waitrequest;
   uav_rdata_t av_rdata;
   uav_cmd_t   uav_cmd;
   logic       uav_waitrequest;
   uav_rdata_t uav_rdata;

   // master side
   av_cmd_t    stim[$];
   int         stim_idx;
   logic       av_busy;
   logic       av_taken;

   // responder queues with one entry per accepted read
   uav_addr_t  rd_addr_q[$];
   uav_burst_t rd_len_q[$];
   uav_addr_t  ret_addr;
   uav_burst_t ret_left;
   logic [2:0] ret_gap;

   int         cycle;
   int         limit;

   `include "xlat_model.svh"

   always #(CLK_PERIOD / 2) clk = ~clk;

   xlat_top xlat_top_i (
      .clk             (clk),
      .reset           (reset),
      .av_cmd          (av_cmd),
      .av_waitrequest  (av_waitrequest),
      .av_rdata        (av_rdata),
      .uav_cmd         (uav_cmd),
      .uav_waitrequest (uav_waitrequest),
      .uav_rdata       (uav_rdata)
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped at the first error");
   endtask

   // ----------------------------------------------------------------------
   // stimulus
   // ----------------------------------------------------------------------
   task automatic build_stimulus();
      av_cmd_t     c;
      logic [31:0] r;
      av_burst_t   len;
      int          n;
      for (n = 0; n < NUM_CMDS; n++) begin
         r            = next_rand();
         len          = av_burst_t'(r[2:0]) + 4'd1;
         c            = '0;
         c.address    = av_addr_t'(next_rand());
         c.burstcount = len;
         if (r[3]) begin
            c.read       = 1'b1;
            c.byteenable = r[7:4];
            stim.push_back(c);
         end else begin
            // master repeats address and count on every beat of the burst
            c.write = 1'b1;
            repeat (len) begin
               r            = next_rand();
               c.byteenable = r[3:0];
               c.writedata  = next_rand();
               stim.push_back(c);
            end
         end
      end
   endtask

   task automatic drive_master();
      logic [31:0] r;
      r = next_rand();
      if (!av_busy || av_taken) begin
         // about one cycle in four idle even inside write bursts
         if (stim_idx < stim.size() && r[1:0] != 2'd0) begin
            av_cmd   = stim[stim_idx];
            stim_idx++;
            av_busy  = 1'b1;
         end else begin
            av_cmd  = '0;
            av_busy = 1'b0;
         end
      end
   endtask

   task automatic drive_responder();
      logic [31:0] r;
      r               = next_rand();
      uav_waitrequest = (r[2:0] < 3'd3);
      uav_rdata       = '0;
      if (ret_left == '0 && rd_addr_q.size() != 0) begin
         ret_addr = rd_addr_q.pop_front();
         ret_left = rd_len_q.pop_front();
         ret_gap  = r[6:4];
      end
      if (ret_left != '0) begin
         if (ret_gap != 3'd0) begin
            ret_gap = ret_gap - 3'd1;
         end else if (r[9:8] != 2'd0) begin
            uav_rdata.readdatavalid = 1'b1;
            uav_rdata.readdata      = ret_addr ^ RD_KEY;
            ret_addr                = ret_addr + 32'd4;
            ret_left                = ret_left - 6'd1;
         end
      end
   endtask

   // ----------------------------------------------------------------------
   // monitor sampling in the middle of the low clock phase
   // ----------------------------------------------------------------------
   task automatic sample_cycle();
      check_bus_idle();
      av_taken = av_busy && !av_waitrequest;
      if (av_taken) begin
         record_upstream(av_cmd);
      end
      if ((uav_cmd.write || uav_cmd.read) && !uav_waitrequest) begin
         check_beat(uav_cmd);
         if (uav_cmd.read) begin
            rd_addr_q.push_back(uav_cmd.address);
            rd_len_q.push_back(uav_cmd.burstcount / 6'd4);
         end
      end
      if (av_rdata.readdatavalid) begin
         check_read_word(av_rdata.readdata);
      end
   endtask

   task automatic step_cycle();
      @(negedge clk);
      drive_master();
      drive_responder();
      #(CLK_PERIOD / 4);
      sample_cycle();
      cycle++;
      if (cycle > limit) begin
         abort_run($sformatf("timeout: traffic still outstanding after %0d cycles", cycle));
      end
   endtask

   initial begin
      clk             = 1'b0;
      reset           = 1'b1;
      av_cmd          = '0;
      uav_waitrequest = 1'b0;
      uav_rdata       = '0;
      rng_state       = 32'h41c1;
      stim_idx        = 0;
      av_busy         = 1'b0;
      av_taken        = 1'b0;
      ret_addr        = '0;
      ret_left        = '0;
      ret_gap         = '0;
      cycle           = 0;
      clear_model();
      build_stimulus();
      limit = CYCLES_PER_BEAT * stim.size() + TIMEOUT_MARGIN;

      repeat (RESET_CYCLES) begin
         @(negedge clk);
         check_bus_idle();
      end
      reset = 1'b0;
      #(CLK_PERIOD / 4);
      assert (!av_waitrequest)
         else abort_run("av_waitrequest is high after reset although the stages are empty");

      while (stim_idx < stim.size() || av_busy || exp_beats.size() != 0 ||
             exp_words.size() != 0) begin
         step_cycle();
      end
      // quiet tail where any further beat or word is unexpected
      repeat (20) step_cycle();

      $display("%0d upstream beats, %0d downstream beats, %0d read words",
               stim.size(), beats_seen, words_seen);
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

/* files.f */
+incdir+design
+incdir+dv
design/av_side_pkg.sv
design/uav_side_pkg.sv
design/pipe_stage.sv
design/cmd_widen.sv
design/beat_tracker.sv
design/xlat_top.sv
dv/tb_xlat_top.sv

/* Makefile */
# Verilator build and run of the master translator testbench
# any variable below can be set on the command line, e.g. make run OBJ_DIR=./build

VERILATOR ?= verilator
TOP       ?= tb_xlat_top
FILE_LIST ?= files.f
OBJ_DIR   ?= ./obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv design/*.svh dv/*.sv dv/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass or fail is taken from the simulation output alone
run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
